/* source/ooo_pkg.sv */
/*
  shared sizes, index types, opcodes and the dispatch bundle
  preg 0 stands for x0 and is never allocated or freed
*/
`default_nettype none

package ooo_pkg;

    // machine sizes
    localparam int arch_regs     = 32;
    localparam int num_pregs     = 64;
    localparam int station_depth = 16;
    localparam int rob_depth     = 16;

    // index types follow the sizes
    typedef logic [$clog2(arch_regs)-1:0] areg_t;
    typedef logic [$clog2(num_pregs)-1:0] preg_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

    // rv32 major opcodes that are renamed
    // anything else passes through as a no-op
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // renamed instruction, one per dispatch
    typedef struct packed {
        logic [31:0] inst;
        rob_idx_t    rob_idx;
        // zero when there is no destination
        areg_t       arch_rd;
        preg_t       preg_rd;
        // mapping of arch_rd before this rename
        preg_t       preg_old;
        preg_t       preg_rs1;
        preg_t       preg_rs2;
        logic        uses_rs1;
        logic        uses_rs2;
    } dispatch_t;

endpackage

`default_nettype wire

/* source/dispatch_if.sv */
/*
  renamed bundle from rename to station and reorder buffer
  no handshake: both consumers take the bundle when valid is high
*/
`default_nettype none
`timescale 1ns/1ps

interface dispatch_if;

    logic               valid;
    ooo_pkg::dispatch_t bundle;
    // next free rob slot, in-flight bundle already counted
    ooo_pkg::rob_idx_t  rob_tail;
    // at least two rob slots free
    logic               rob_room;

    modport producer (output valid, output bundle, input rob_tail, input rob_room);

    // reservation station side
    modport consumer (input valid, input bundle);

    // reorder buffer side, also reports its allocation state
    modport rob_consumer (input valid, input bundle, output rob_tail, output rob_room);

endinterface

`default_nettype wire

/* source/rename_stage.sv */
/*
  decode, alias table and free list, one instruction per cycle
  in_inst must be held while in_ready is low
  sources not read by the opcode are renamed to preg 0
*/
`default_nettype none
`timescale 1ns/1ps

module rename_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [31:0]         in_inst,
    output logic                in_ready,
    input  logic                station_room,
    input  logic                free_valid,
    input  ooo_pkg::preg_t      free_preg,
    dispatch_if.producer        disp
);

    // free list holds every preg above the initial mapping
    typedef logic [$clog2(ooo_pkg::num_pregs - ooo_pkg::arch_regs)-1:0] fl_ptr_t;
    typedef logic [$clog2(ooo_pkg::num_pregs - ooo_pkg::arch_regs):0]   fl_cnt_t;

    ooo_pkg::preg_t     rat [ooo_pkg::arch_regs];
    ooo_pkg::preg_t     free_fifo [ooo_pkg::num_pregs - ooo_pkg::arch_regs];
    fl_ptr_t            fl_head;
    fl_ptr_t            fl_tail;
    fl_cnt_t            fl_count;

    ooo_pkg::opcode_e   opcode;
    ooo_pkg::areg_t     rd;
    ooo_pkg::areg_t     rs1;
    ooo_pkg::areg_t     rs2;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               writes_rd;
    logic               has_rd;
    logic               accept;
    ooo_pkg::dispatch_t next_bundle;

    // field extraction
    assign opcode = ooo_pkg::opcode_e'(in_inst[6:0]);
    assign rd     = in_inst[11:7];
    assign rs1    = in_inst[19:15];
    assign rs2    = in_inst[24:20];

    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            ooo_pkg::op_reg: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            ooo_pkg::op_imm: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            ooo_pkg::op_lui: begin
                writes_rd = 1'b1;
            end
            default: begin
                // no-op, nothing renamed
            end
        endcase
    end

    // x0 as destination takes no preg
    assign has_rd = writes_rd && (rd != '0);

    // room checks keep a slot spare for the bundle in flight
    assign in_ready = ((fl_count != '0) || !has_rd) && station_room && disp.rob_room;
    assign accept   = in_valid && in_ready;

    // sources read the table before this rename updates it
    always_comb begin
        next_bundle.inst     = in_inst;
        next_bundle.rob_idx  = disp.rob_tail;
        next_bundle.arch_rd  = has_rd ? rd : '0;
        next_bundle.preg_rd  = has_rd ? free_fifo[fl_head] : '0;
        next_bundle.preg_old = has_rd ? rat[rd] : '0;
        next_bundle.preg_rs1 = uses_rs1 ? rat[rs1] : '0;
        next_bundle.preg_rs2 = uses_rs2 ? rat[rs2] : '0;
        next_bundle.uses_rs1 = uses_rs1;
        next_bundle.uses_rs2 = uses_rs2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping, upper pregs free in ascending order
            for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
                rat[i] <= ooo_pkg::preg_t'(i);
            end
            for (int i = 0; i < ooo_pkg::num_pregs - ooo_pkg::arch_regs; i++) begin
                free_fifo[i] <= ooo_pkg::preg_t'(ooo_pkg::arch_regs + i);
            end
            fl_head    <= '0;
            fl_tail    <= '0;
            fl_count   <= fl_cnt_t'(ooo_pkg::num_pregs - ooo_pkg::arch_regs);
            disp.valid <= 1'b0;
        end else begin
            // pop at head for a new destination
            if (accept && has_rd) begin
                rat[rd] <= free_fifo[fl_head];
                fl_head <= fl_head + 1'b1;
            end
            // commit pushes the superseded preg at tail
            if (free_valid) begin
                free_fifo[fl_tail] <= free_preg;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({accept && has_rd, free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
            disp.valid <= accept;
        end
    end

    // bundle register, only meaningful with disp.valid
    always_ff @(posedge clk) begin
        if (accept) begin
            disp.bundle <= next_bundle;
        end
    end

endmodule

`default_nettype wire

/* source/issue_station.sv */
/*
  reservation station, one issue per cycle, highest ready index wins
  execute unit must take every issued instruction, no stall input
  station_room means two or more free entries
*/
`default_nettype none
`timescale 1ns/1ps

module issue_station (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.consumer        disp,
    output logic                station_room,
    input  logic                wb_valid,
    input  ooo_pkg::preg_t      wb_preg,
    output logic                issue_valid,
    output logic [31:0]         issue_inst,
    output ooo_pkg::rob_idx_t   issue_rob_idx,
    output ooo_pkg::preg_t      issue_rs1,
    output ooo_pkg::preg_t      issue_rs2,
    output ooo_pkg::preg_t      issue_rd
);

    typedef logic [$clog2(ooo_pkg::station_depth)-1:0] slot_t;
    typedef logic [$clog2(ooo_pkg::station_depth):0]   cnt_t;

    ooo_pkg::dispatch_t                 entry [ooo_pkg::station_depth];
    logic [ooo_pkg::station_depth-1:0]  entry_valid;
    logic [ooo_pkg::station_depth-1:0]  rs1_rdy;
    logic [ooo_pkg::station_depth-1:0]  rs2_rdy;
    // one bit per preg, set when its value exists
    logic [ooo_pkg::num_pregs-1:0]      preg_ready;
    cnt_t                               count;
    slot_t                              alloc_slot;
    slot_t                              sel_slot;
    logic                               sel_found;
    logic                               new_rs1_rdy;
    logic                               new_rs2_rdy;

    assign station_room = (count <= cnt_t'(ooo_pkg::station_depth - 2));

    // lowest free slot for the incoming bundle
    always_comb begin
        alloc_slot = '0;
        for (int i = ooo_pkg::station_depth - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                alloc_slot = slot_t'(i);
            end
        end
    end

    // highest ready slot, later matches override
    always_comb begin
        sel_found = 1'b0;
        sel_slot  = '0;
        for (int i = 0; i < ooo_pkg::station_depth; i++) begin
            if (entry_valid[i] && rs1_rdy[i] && rs2_rdy[i]) begin
                sel_found = 1'b1;
                sel_slot  = slot_t'(i);
            end
        end
    end

    // source check at dispatch, same-cycle writeback bypassed
    assign new_rs1_rdy = !disp.bundle.uses_rs1 || preg_ready[disp.bundle.preg_rs1] ||
                         (wb_valid && (wb_preg == disp.bundle.preg_rs1));
    assign new_rs2_rdy = !disp.bundle.uses_rs2 || preg_ready[disp.bundle.preg_rs2] ||
                         (wb_valid && (wb_preg == disp.bundle.preg_rs2));

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            count       <= '0;
            // initial mappings all hold values
            preg_ready  <= '1;
            issue_valid <= 1'b0;
        end else begin
            if (sel_found) begin
                entry_valid[sel_slot] <= 1'b0;
            end
            if (disp.valid) begin
                entry_valid[alloc_slot] <= 1'b1;
                // preg 0 stays ready
                if (disp.bundle.preg_rd != '0) begin
                    preg_ready[disp.bundle.preg_rd] <= 1'b0;
                end
            end
            if (wb_valid) begin
                preg_ready[wb_preg] <= 1'b1;
            end
            case ({disp.valid, sel_found})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            issue_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        // wakeup, stale slots may match too and are rewritten on alloc
        for (int i = 0; i < ooo_pkg::station_depth; i++) begin
            if (wb_valid && (entry[i].preg_rs1 == wb_preg)) begin
                rs1_rdy[i] <= 1'b1;
            end
            if (wb_valid && (entry[i].preg_rs2 == wb_preg)) begin
                rs2_rdy[i] <= 1'b1;
            end
        end
        if (disp.valid) begin
            entry[alloc_slot]   <= disp.bundle;
            rs1_rdy[alloc_slot] <= new_rs1_rdy;
            rs2_rdy[alloc_slot] <= new_rs2_rdy;
        end
        // issue payload
        if (sel_found) begin
            issue_inst    <= entry[sel_slot].inst;
            issue_rob_idx <= entry[sel_slot].rob_idx;
            issue_rs1     <= entry[sel_slot].preg_rs1;
            issue_rs2     <= entry[sel_slot].preg_rs2;
            issue_rd      <= entry[sel_slot].preg_rd;
        end
    end

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
/*
  in-order retirement, at most one commit per cycle
  entries without a destination are allocated complete
  execute must not write back an entry without a destination
*/
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    dispatch_if.rob_consumer    disp,
    input  logic                wb_valid,
    input  ooo_pkg::rob_idx_t   wb_rob_idx,
    output logic                commit_valid,
    output ooo_pkg::areg_t      commit_arch_rd,
    output ooo_pkg::preg_t      commit_preg,
    output ooo_pkg::preg_t      commit_preg_old,
    output logic                free_valid,
    output ooo_pkg::preg_t      free_preg
);

    typedef logic [$clog2(ooo_pkg::rob_depth):0] cnt_t;

    ooo_pkg::areg_t             arch_rd_q  [ooo_pkg::rob_depth];
    ooo_pkg::preg_t             preg_q     [ooo_pkg::rob_depth];
    ooo_pkg::preg_t             preg_old_q [ooo_pkg::rob_depth];
    logic [ooo_pkg::rob_depth-1:0] done;
    ooo_pkg::rob_idx_t          head;
    ooo_pkg::rob_idx_t          tail;
    cnt_t                       count;
    logic                       retire;

    // rename sees the slot after any bundle still in flight
    assign disp.rob_tail = tail + ooo_pkg::rob_idx_t'(disp.valid);
    assign disp.rob_room = (count <= cnt_t'(ooo_pkg::rob_depth - 2));

    assign retire = (count != '0) && done[head];

    // superseded preg goes back to rename with the commit
    assign free_valid = commit_valid && (commit_arch_rd != '0);
    assign free_preg  = commit_preg_old;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (disp.valid) begin
                done[tail] <= (disp.bundle.arch_rd == '0);
                tail       <= tail + 1'b1;
            end
            if (wb_valid) begin
                done[wb_rob_idx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({disp.valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            arch_rd_q[tail]  <= disp.bundle.arch_rd;
            preg_q[tail]     <= disp.bundle.preg_rd;
            preg_old_q[tail] <= disp.bundle.preg_old;
        end
        // head entry onto the commit port
        if (retire) begin
            commit_arch_rd  <= arch_rd_q[head];
            commit_preg     <= preg_q[head];
            commit_preg_old <= preg_old_q[head];
        end
    end

endmodule

`default_nettype wire

/* source/ooo_core.sv */
/*
  rename and dispatch core: rename, then station and rob, then commit
  issue and commit take no back-pressure
  in_inst must be held while in_ready is low
*/
`default_nettype none
`timescale 1ns/1ps

module ooo_core (
    input  logic                clk,
    input  logic                rst,
    // instruction input
    input  logic                in_valid,
    input  logic [31:0]         in_inst,
    output logic                in_ready,
    // issue to execute
    output logic                issue_valid,
    output logic [31:0]         issue_inst,
    output ooo_pkg::rob_idx_t   issue_rob_idx,
    output ooo_pkg::preg_t      issue_rs1,
    output ooo_pkg::preg_t      issue_rs2,
    output ooo_pkg::preg_t      issue_rd,
    // writeback from execute
    input  logic                wb_valid,
    input  ooo_pkg::preg_t      wb_preg,
    input  ooo_pkg::rob_idx_t   wb_rob_idx,
    // commit
    output logic                commit_valid,
    output ooo_pkg::areg_t      commit_arch_rd,
    output ooo_pkg::preg_t      commit_preg,
    output ooo_pkg::preg_t      commit_preg_old
);

    logic           station_room;
    logic           free_valid;
    ooo_pkg::preg_t free_preg;

    dispatch_if disp_bus ();

    rename_stage rename_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_ready     (in_ready),
        .station_room (station_room),
        .free_valid   (free_valid),
        .free_preg    (free_preg),
        .disp         (disp_bus.producer)
    );

    issue_station station_i (
        .clk           (clk),
        .rst           (rst),
        .disp          (disp_bus.consumer),
        .station_room  (station_room),
        .wb_valid      (wb_valid),
        .wb_preg       (wb_preg),
        .issue_valid   (issue_valid),
        .issue_inst    (issue_inst),
        .issue_rob_idx (issue_rob_idx),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_rd      (issue_rd)
    );

    reorder_buffer rob_i (
        .clk             (clk),
        .rst             (rst),
        .disp            (disp_bus.rob_consumer),
        .wb_valid        (wb_valid),
        .wb_rob_idx      (wb_rob_idx),
        .commit_valid    (commit_valid),
        .commit_arch_rd  (commit_arch_rd),
        .commit_preg     (commit_preg),
        .commit_preg_old (commit_preg_old),
        .free_valid      (free_valid),
        .free_preg       (free_preg)
    );

endmodule

`default_nettype wire

/* bench/ooo_core_checker.sv */
/*
  bound into ooo_core, reports through failing assertions only
  reset checks look at the first edge after rst falls
*/
`default_nettype none
`timescale 1ns/1ps

module ooo_core_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_ready,
    input  logic           issue_valid,
    input  logic           commit_valid,
    input  ooo_pkg::areg_t commit_arch_rd,
    input  ooo_pkg::preg_t commit_preg,
    input  ooo_pkg::preg_t commit_preg_old
);

    // nothing issued or committed straight out of reset
    assert property (@(posedge clk) $fell(rst) |-> !issue_valid && !commit_valid)
        else $error("issue or commit valid right after reset");

    // core accepts immediately after reset
    assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else $error("in_ready low right after reset");

    // a rename always takes a fresh preg
    assert property (@(posedge clk) disable iff (rst)
        commit_valid && (commit_arch_rd != '0) |-> commit_preg_old != commit_preg)
        else $error("commit with old mapping equal to new mapping");

endmodule

bind ooo_core ooo_core_checker checker_i (
    .clk             (clk),
    .rst             (rst),
    .in_ready        (in_ready),
    .issue_valid     (issue_valid),
    .commit_valid    (commit_valid),
    .commit_arch_rd  (commit_arch_rd),
    .commit_preg     (commit_preg),
    .commit_preg_old (commit_preg_old)
);

`default_nettype wire

/* bench/ooo_core_tb.sv */
/*
  testbench for ooo_core with execute and reference models
  one writeback per cycle, none for instructions without a destination
  rd=x0 rows only read registers that are long ready
*/
`default_nettype none
`timescale 1ns/1ps

module ooo_core_tb;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic [31:0]         in_inst;
    logic                in_ready;
    logic                issue_valid;
    logic [31:0]         issue_inst;
    ooo_pkg::rob_idx_t   issue_rob_idx;
    ooo_pkg::preg_t      issue_rs1;
    ooo_pkg::preg_t      issue_rs2;
    ooo_pkg::preg_t      issue_rd;
    logic                wb_valid;
    ooo_pkg::preg_t      wb_preg;
    ooo_pkg::rob_idx_t   wb_rob_idx;
    logic                commit_valid;
    ooo_pkg::areg_t      commit_arch_rd;
    ooo_pkg::preg_t      commit_preg;
    ooo_pkg::preg_t      commit_preg_old;

    // stimulus table, instruction and writeback delay per row
    logic [31:0] tbl_inst [$];
    int          tbl_delay [$];
    bit          table_built;

    // reference model state
    ooo_pkg::preg_t ref_rat [ooo_pkg::arch_regs];
    ooo_pkg::preg_t ref_free [$];
    bit             ref_ready [ooo_pkg::num_pregs];

    // per accepted instruction, indexed by acceptance order
    logic [31:0]    rec_inst [256];
    ooo_pkg::preg_t rec_rs1 [256];
    ooo_pkg::preg_t rec_rs2 [256];
    ooo_pkg::preg_t rec_rd [256];
    ooo_pkg::preg_t rec_old [256];
    ooo_pkg::areg_t rec_ard [256];
    bit             rec_use1 [256];
    bit             rec_use2 [256];
    int             rec_delay [256];
    bit             rec_issued [256];

    // execute model pending writebacks
    int                pend_due [$];
    ooo_pkg::preg_t    pend_preg [$];
    ooo_pkg::rob_idx_t pend_rob [$];

    int  cycle;
    int  cur_row;
    int  accepted;
    int  committed;
    int  issued;
    int  errors;
    int  tests_run;
    int  tests_failed;
    bit  hold_wb;
    bit  rand_phase;
    bit  bp_check;
    bit  sender_done;

    ooo_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] r_op(input int rd, input int rs1, input int rs2);
        return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_op(input int rd, input int rs1);
        return {12'd5, 5'(rs1), 3'd0, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] u_op(input int rd);
        return {20'h12345, 5'(rd), 7'b0110111};
    endfunction

    task automatic add_row(input logic [31:0] inst, input int delay);
        tbl_inst.push_back(inst);
        tbl_delay.push_back(delay);
    endtask

    task automatic check_preg(input string what, input ooo_pkg::preg_t got,
                              input ooo_pkg::preg_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_areg(input string what, input ooo_pkg::areg_t got,
                              input ooo_pkg::areg_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_rob(input string what, input ooo_pkg::rob_idx_t got,
                             input ooo_pkg::rob_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // reference rename at the edge that accepts the instruction
    task automatic model_accept();
        logic [6:0] op;
        int         rd;
        bit         use1;
        bit         use2;
        bit         has_rd;
        int         seq;
        op     = in_inst[6:0];
        rd     = int'(in_inst[11:7]);
        use1   = (op == ooo_pkg::op_reg) || (op == ooo_pkg::op_imm);
        use2   = (op == ooo_pkg::op_reg);
        has_rd = (use1 || (op == ooo_pkg::op_lui)) && (rd != 0);
        seq    = accepted;
        rec_inst[seq]   = in_inst;
        rec_use1[seq]   = use1;
        rec_use2[seq]   = use2;
        rec_rs1[seq]    = use1 ? ref_rat[in_inst[19:15]] : '0;
        rec_rs2[seq]    = use2 ? ref_rat[in_inst[24:20]] : '0;
        rec_ard[seq]    = has_rd ? ooo_pkg::areg_t'(rd) : '0;
        rec_old[seq]    = has_rd ? ref_rat[rd] : '0;
        rec_rd[seq]     = '0;
        rec_delay[seq]  = tbl_delay[cur_row];
        rec_issued[seq] = 1'b0;
        if (has_rd) begin
            if (ref_free.size() == 0) begin
                $display("instruction accepted while the free list is empty");
                errors++;
            end else begin
                rec_rd[seq]        = ref_free.pop_front();
                ref_rat[rd]        = rec_rd[seq];
                ref_ready[rec_rd[seq]] = 1'b0;
            end
        end
        accepted++;
    endtask

    task automatic model_issue();
        int seq;
        int extra;
        // oldest accepted instruction with this word not yet issued
        seq = -1;
        for (int s = accepted - 1; s >= 0; s--) begin
            if (!rec_issued[s] && (rec_inst[s] == issue_inst)) begin
                seq = s;
            end
        end
        if (seq < 0) begin
            $display("issued word %h matches no accepted instruction waiting to issue",
                     issue_inst);
            errors++;
            return;
        end
        rec_issued[seq] = 1'b1;
        issued++;
        check_word("issue_inst", issue_inst, rec_inst[seq]);
        check_rob("issue_rob_idx", issue_rob_idx, ooo_pkg::rob_idx_t'(seq));
        check_preg("issue_rs1", issue_rs1, rec_rs1[seq]);
        check_preg("issue_rs2", issue_rs2, rec_rs2[seq]);
        check_preg("issue_rd", issue_rd, rec_rd[seq]);
        if ((rec_use1[seq] && !ref_ready[rec_rs1[seq]]) ||
            (rec_use2[seq] && !ref_ready[rec_rs2[seq]])) begin
            $display("instruction %0d issued before its sources were written back", seq);
            errors++;
        end
        extra = rand_phase ? int'($urandom_range(0, 7)) : 0;
        if (rec_rd[seq] != '0) begin
            pend_due.push_back(cycle + rec_delay[seq] + extra);
            pend_preg.push_back(rec_rd[seq]);
            pend_rob.push_back(issue_rob_idx);
        end
    endtask

    task automatic model_commit();
        int seq;
        seq = committed;
        check_areg("commit_arch_rd", commit_arch_rd, rec_ard[seq]);
        check_preg("commit_preg", commit_preg, rec_rd[seq]);
        check_preg("commit_preg_old", commit_preg_old, rec_old[seq]);
        if (rec_ard[seq] != '0) begin
            ref_free.push_back(rec_old[seq]);
        end
        committed++;
    endtask

    // outputs sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (!rst) begin
            if ((issue_valid || commit_valid) && accepted == 0) begin
                $display("issue or commit seen before any instruction was accepted");
                errors++;
            end
            if (in_valid && in_ready) begin
                model_accept();
            end
            if (issue_valid) begin
                model_issue();
            end
            // sampled at the coming edge, before any later select
            if (wb_valid) begin
                ref_ready[wb_preg] = 1'b1;
            end
            if (commit_valid) begin
                model_commit();
            end
            if (bp_check && (accepted - committed > 16)) begin
                $display("more than 16 instructions outstanding while writebacks are held");
                errors++;
            end
        end
    end

    // execute model, one writeback per cycle
    always @(posedge clk) begin
        int idx;
        idx = -1;
        #1;
        if (!hold_wb) begin
            for (int i = 0; i < pend_due.size(); i++) begin
                if (idx < 0 && pend_due[i] <= cycle) begin
                    idx = i;
                end
            end
        end
        if (idx >= 0) begin
            wb_valid   = 1'b1;
            wb_preg    = pend_preg[idx];
            wb_rob_idx = pend_rob[idx];
            pend_due.delete(idx);
            pend_preg.delete(idx);
            pend_rob.delete(idx);
        end else begin
            wb_valid = 1'b0;
        end
    end

    task automatic send_rows(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_inst  = tbl_inst[r];
            cur_row  = r;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (committed != accepted || issued != accepted || pend_due.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic build_table();
        // dependence chain with a rd=x0 row and a no-op
        add_row(u_op(1), 3);
        add_row(i_op(2, 1), 2);
        add_row(r_op(3, 1, 2), 1);
        add_row(i_op(0, 5), 0);
        add_row(32'h0000_000f, 0);
        add_row(r_op(4, 3, 3), 4);
        add_row(i_op(1, 4), 0);
        add_row(r_op(5, 1, 2), 2);
        // long delays first, short later
        add_row(u_op(6), 30);
        add_row(u_op(7), 25);
        add_row(u_op(8), 20);
        add_row(i_op(9, 0), 10);
        add_row(i_op(10, 0), 2);
        add_row(i_op(11, 0), 1);
        add_row(u_op(12), 0);
        add_row(r_op(13, 10, 11), 0);
        // recycling, rows 16 to 45
        for (int i = 0; i < 30; i++) begin
            add_row(i_op(14 + i % 10, 14 + (i + 9) % 10), i % 4);
        end
        // back-pressure, rows 46 to 65
        for (int i = 0; i < 20; i++) begin
            add_row(r_op(20 + i % 8, 1, 2), 0);
        end
        // random delays, rows 66 to 81
        for (int i = 0; i < 16; i++) begin
            add_row(r_op(i % 31 + 1, (i * 7) % 32, (i * 3) % 32), 1);
        end
        table_built = 1'b1;
    endtask

    initial begin
        wait (table_built);
        #((tbl_inst.size() * 64 + 1000) * 8);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int err_before;
        int waited;
        void'($urandom(22626));
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        wb_valid = 1'b0;
        wb_preg = '0;
        wb_rob_idx = '0;
        for (int i = 0; i < ooo_pkg::arch_regs; i++) begin
            ref_rat[i] = ooo_pkg::preg_t'(i);
            ref_free.push_back(ooo_pkg::preg_t'(ooo_pkg::arch_regs + i));
        end
        for (int i = 0; i < ooo_pkg::num_pregs; i++) begin
            ref_ready[i] = 1'b1;
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        err_before = errors;
        repeat (3) @(negedge clk);
        if (!in_ready) begin
            $display("in_ready is low after reset");
            errors++;
        end
        report_test("reset", err_before);

        err_before = errors;
        send_rows(0, 7);
        wait_drain();
        report_test("renaming and dependences", err_before);

        err_before = errors;
        send_rows(8, 15);
        wait_drain();
        report_test("in-order commit", err_before);

        err_before = errors;
        send_rows(16, 45);
        wait_drain();
        report_test("register recycling", err_before);

        // writebacks withheld until in_ready falls
        err_before = errors;
        hold_wb = 1'b1;
        bp_check = 1'b1;
        fork
            begin
                send_rows(46, 65);
                sender_done = 1'b1;
            end
        join_none
        waited = 0;
        @(negedge clk);
        while (in_ready && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready) begin
            $display("in_ready never fell while writebacks were held");
            errors++;
        end
        bp_check = 1'b0;
        hold_wb = 1'b0;
        wait (sender_done);
        wait_drain();
        report_test("back-pressure", err_before);

        err_before = errors;
        rand_phase = 1'b1;
        send_rows(66, tbl_inst.size() - 1);
        wait_drain();
        if (accepted != tbl_inst.size() || committed != accepted || issued != accepted) begin
            $display("rows accepted %0d, issued %0d, committed %0d, expected %0d each",
                     accepted, issued, committed, tbl_inst.size());
            errors++;
        end
        report_test("random delays", err_before);

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_core.f */
source/ooo_pkg.sv
source/dispatch_if.sv
source/rename_stage.sv
source/issue_station.sv
source/reorder_buffer.sv
source/ooo_core.sv
bench/ooo_core_checker.sv
bench/ooo_core_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb -Mdir obj_dir -f ooo_core.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vooo_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
